// File: rtl/cpu_settings.svh
`ifndef CPU_SETTINGS_SVH
`define CPU_SETTINGS_SVH

// datapath and address width
`define XLEN 32

// register file shape
`define REG_ADDR_W 5
`define REG_COUNT 32

// memory depths in words
`define IMEM_DEPTH 256
`define DMEM_DEPTH 256

// byte step between instructions
`define PC_STEP 4

// ecall halt rule, halt when x17 holds 10
`define HALT_REG 17
`define HALT_CODE 10

`endif

// File: rtl/isa_pkg.sv
`include "cpu_settings.svh"

package isa_pkg;

  // major opcodes, bits [6:0]
  typedef enum logic [6:0] {
    op_r      = 7'b0110011,  // register-register alu
    op_imm    = 7'b0010011,  // register-immediate alu
    op_load   = 7'b0000011,
    op_store  = 7'b0100011,
    op_branch = 7'b1100011,
    op_jal    = 7'b1101111,
    op_jalr   = 7'b1100111,
    op_system = 7'b1110011   // ecall only
  } opcode_e;

  // full alu operation, resolved in decode
  typedef enum logic [3:0] {
    alu_add,
    alu_sub,
    alu_and,
    alu_or,
    alu_xor,
    alu_sll,
    alu_srl,
    alu_slt   // signed
  } alu_op_e;

  // branch conditions, same encoding as funct3
  typedef enum logic [2:0] {
    br_eq = 3'b000,
    br_ne = 3'b001,
    br_lt = 3'b100,
    br_ge = 3'b101
  } branch_e;

endpackage

// File: rtl/pipe_pkg.sv
`include "cpu_settings.svh"

package pipe_pkg;

  // writeback value source
  typedef enum logic {
    wb_exec,  // alu result or link value
    wb_mem    // load data
  } wb_sel_e;

  // operand source in execute
  typedef enum logic [1:0] {
    fwd_reg,  // value read in decode
    fwd_mem,  // from ex/mem
    fwd_wb    // from mem/wb
  } fwd_sel_e;

  // kind of control transfer
  typedef enum logic [1:0] {
    xfer_none,
    xfer_branch,
    xfer_jal,
    xfer_jalr
  } xfer_e;

endpackage

// File: rtl/decode_unit.sv
`include "cpu_settings.svh"

module decode_unit
  import isa_pkg::*, pipe_pkg::*;
(
  input  logic [`XLEN-1:0] instr,
  output logic             reg_write,
  output logic             mem_read,
  output logic             mem_write,
  output wb_sel_e          wb_sel,
  output logic             alu_src,   // 1 selects imm as operand b
  output alu_op_e          alu_op,
  output xfer_e            xfer,
  output logic             is_ecall,
  output logic             uses_rs1,
  output logic             uses_rs2,
  output logic [`XLEN-1:0] imm
);

  logic [2:0]       funct3;
  logic [`XLEN-1:0] imm_i;
  logic [`XLEN-1:0] imm_s;
  logic [`XLEN-1:0] imm_b;
  logic [`XLEN-1:0] imm_j;

  assign funct3 = instr[14:12];
  assign imm_i  = {{20{instr[31]}}, instr[31:20]};
  assign imm_s  = {{20{instr[31]}}, instr[31:25], instr[11:7]};
  assign imm_b  = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
  assign imm_j  = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

  always_comb begin
    reg_write = 1'b0;  // defaults give a bubble
    mem_read  = 1'b0;
    mem_write = 1'b0;
    wb_sel    = wb_exec;
    alu_src   = 1'b0;
    alu_op    = alu_add;
    xfer      = xfer_none;
    is_ecall  = 1'b0;
    uses_rs1  = 1'b0;
    uses_rs2  = 1'b0;
    imm       = '0;
    case (opcode_e'(instr[6:0]))
      op_r: begin
        reg_write = 1'b1;
        uses_rs1  = 1'b1;
        uses_rs2  = 1'b1;
        case (funct3)
          3'b000:  alu_op = instr[30] ? alu_sub : alu_add;  // funct7 bit picks sub
          3'b001:  alu_op = alu_sll;
          3'b010:  alu_op = alu_slt;
          3'b100:  alu_op = alu_xor;
          3'b101:  alu_op = alu_srl;
          3'b110:  alu_op = alu_or;
          3'b111:  alu_op = alu_and;
          default: reg_write = 1'b0;  // sltu unsupported
        endcase
      end
      op_imm: begin
        reg_write = 1'b1;
        uses_rs1  = 1'b1;
        alu_src   = 1'b1;
        imm       = imm_i;
        case (funct3)
          3'b000:  alu_op = alu_add;
          3'b100:  alu_op = alu_xor;
          3'b110:  alu_op = alu_or;
          3'b111:  alu_op = alu_and;
          default: reg_write = 1'b0;  // shifts and slti not in subset
        endcase
      end
      op_load: begin
        reg_write = 1'b1;
        mem_read  = 1'b1;
        wb_sel    = wb_mem;
        uses_rs1  = 1'b1;
        alu_src   = 1'b1;
        imm       = imm_i;
      end
      op_store: begin
        mem_write = 1'b1;
        uses_rs1  = 1'b1;
        uses_rs2  = 1'b1;  // store data
        alu_src   = 1'b1;
        imm       = imm_s;
      end
      op_branch: begin
        imm = imm_b;
        case (funct3)
          3'b000, 3'b001, 3'b100, 3'b101: begin
            xfer     = xfer_branch;
            uses_rs1 = 1'b1;
            uses_rs2 = 1'b1;
          end
          default: xfer = xfer_none;  // unsigned compares unsupported
        endcase
      end
      op_jal: begin
        reg_write = 1'b1;  // link
        xfer      = xfer_jal;
        imm       = imm_j;
      end
      op_jalr: begin
        reg_write = 1'b1;
        xfer      = xfer_jalr;
        uses_rs1  = 1'b1;
        imm       = imm_i;
      end
      op_system: is_ecall = (instr[31:7] == '0);  // ebreak etc. fall out
      default: is_ecall = 1'b0;
    endcase
  end

endmodule

// File: rtl/reg_file.sv
`include "cpu_settings.svh"

module reg_file (
  input  logic                   clk,
  input  logic [`REG_ADDR_W-1:0] rs1_addr,
  input  logic [`REG_ADDR_W-1:0] rs2_addr,
  input  logic [`REG_ADDR_W-1:0] dbg_addr,
  input  logic [`REG_ADDR_W-1:0] rd_addr,
  input  logic [`XLEN-1:0]       rd_data,
  input  logic                   rd_we,
  output logic [`XLEN-1:0]       rs1_data,
  output logic [`XLEN-1:0]       rs2_data,
  output logic [`XLEN-1:0]       dbg_data
);

  logic [`XLEN-1:0] regs [`REG_COUNT];

  // x0 reads zero, same-cycle write is passed through
  function automatic logic [`XLEN-1:0] read_port(input logic [`REG_ADDR_W-1:0] addr);
    logic [`XLEN-1:0] value;
    if (addr == '0)
      value = '0;
    else if (rd_we && rd_addr == addr)
      value = rd_data;
    else
      value = regs[addr];
    return value;
  endfunction

  always_ff @(posedge clk) begin
    if (rd_we && rd_addr != '0)  // x0 never written
      regs[rd_addr] <= rd_data;
  end

  always_comb begin
    rs1_data = read_port(rs1_addr);
    rs2_data = read_port(rs2_addr);
    dbg_data = read_port(dbg_addr);  // debug port sees writeback too
  end

endmodule

// File: rtl/execute_unit.sv
`include "cpu_settings.svh"

module execute_unit
  import isa_pkg::*, pipe_pkg::*;
(
  input  logic [`XLEN-1:0] pc,
  input  logic [`XLEN-1:0] rs1_data,
  input  logic [`XLEN-1:0] rs2_data,
  input  logic [`XLEN-1:0] imm,
  input  logic             alu_src,
  input  alu_op_e          alu_op,
  input  branch_e          branch_cond,
  input  xfer_e            xfer,
  input  fwd_sel_e         fwd_a,
  input  fwd_sel_e         fwd_b,
  input  logic [`XLEN-1:0] mem_value,   // ex/mem result
  input  logic [`XLEN-1:0] wb_value,    // final writeback value
  output logic [`XLEN-1:0] exec_result,
  output logic [`XLEN-1:0] store_data,
  output logic             redirect,
  output logic [`XLEN-1:0] redirect_pc
);

  logic [`XLEN-1:0] op_a;
  logic [`XLEN-1:0] op_b;
  logic [`XLEN-1:0] alu_result;
  logic [`XLEN-1:0] jalr_sum;
  logic             less;   // signed a < b on forwarded regs
  logic             taken;

  always_comb begin
    case (fwd_a)
      fwd_mem: op_a = mem_value;
      fwd_wb:  op_a = wb_value;
      default: op_a = rs1_data;
    endcase
    case (fwd_b)
      fwd_mem: store_data = mem_value;
      fwd_wb:  store_data = wb_value;
      default: store_data = rs2_data;
    endcase
  end

  assign op_b = alu_src ? imm : store_data;

  always_comb begin
    case (alu_op)
      alu_sub: alu_result = op_a - op_b;
      alu_and: alu_result = op_a & op_b;
      alu_or:  alu_result = op_a | op_b;
      alu_xor: alu_result = op_a ^ op_b;
      alu_sll: alu_result = op_a << op_b[4:0];
      alu_srl: alu_result = op_a >> op_b[4:0];
      alu_slt: alu_result = {{(`XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
      default: alu_result = op_a + op_b;
    endcase
  end

  // branch compare uses both regs, never the imm
  assign less = $signed(op_a) < $signed(store_data);

  always_comb begin
    case (branch_cond)
      br_eq:   taken = (op_a == store_data);
      br_ne:   taken = (op_a != store_data);
      br_lt:   taken = less;
      br_ge:   taken = !less;
      default: taken = 1'b0;
    endcase
  end

  assign jalr_sum    = op_a + imm;
  assign redirect    = (xfer == xfer_jal) || (xfer == xfer_jalr) || (xfer == xfer_branch && taken);
  assign redirect_pc = (xfer == xfer_jalr) ? {jalr_sum[`XLEN-1:1], 1'b0} : pc + imm;

  // jumps write the link address
  assign exec_result = (xfer == xfer_jal || xfer == xfer_jalr) ? pc + `XLEN'(`PC_STEP)
                                                               : alu_result;

endmodule

// File: rtl/hazard_unit.sv
`include "cpu_settings.svh"

module hazard_unit
  import pipe_pkg::*;
(
  input  logic [`REG_ADDR_W-1:0] id_rs1,
  input  logic [`REG_ADDR_W-1:0] id_rs2,
  input  logic                   id_uses_rs1,
  input  logic                   id_uses_rs2,
  input  logic                   id_is_ecall,
  input  logic [`REG_ADDR_W-1:0] ex_rs1,
  input  logic [`REG_ADDR_W-1:0] ex_rs2,
  input  logic [`REG_ADDR_W-1:0] ex_rd,
  input  logic                   ex_mem_read,
  input  logic                   ex_reg_write,
  input  logic [`REG_ADDR_W-1:0] mem_rd,
  input  logic                   mem_reg_write,
  input  logic [`REG_ADDR_W-1:0] wb_rd,
  input  logic                   wb_reg_write,
  input  logic                   redirect,
  output logic                   stall,
  output logic                   flush,
  output fwd_sel_e               fwd_a,
  output fwd_sel_e               fwd_b
);

  logic load_use;
  logic ecall_wait;

  // youngest producer wins, x0 never forwarded
  function automatic fwd_sel_e pick_source(input logic [`REG_ADDR_W-1:0] src);
    fwd_sel_e sel;
    if (mem_reg_write && mem_rd != '0 && mem_rd == src)
      sel = fwd_mem;
    else if (wb_reg_write && wb_rd != '0 && wb_rd == src)
      sel = fwd_wb;
    else
      sel = fwd_reg;
    return sel;
  endfunction

  always_comb begin
    fwd_a = pick_source(ex_rs1);
    fwd_b = pick_source(ex_rs2);
  end

  assign load_use = ex_mem_read && ex_rd != '0 &&
                    ((id_uses_rs1 && ex_rd == id_rs1) || (id_uses_rs2 && ex_rd == id_rs2));

  // ecall waits until x17 writes reach writeback, the rf bypass covers that stage
  assign ecall_wait = id_is_ecall &&
                      ((ex_reg_write && ex_rd == `REG_ADDR_W'(`HALT_REG)) ||
                       (mem_reg_write && mem_rd == `REG_ADDR_W'(`HALT_REG)));

  assign flush = redirect;
  assign stall = (load_use || ecall_wait) && !redirect;  // flush wins

endmodule

// File: rtl/cpu.sv
`include "cpu_settings.svh"

module cpu
  import isa_pkg::*, pipe_pkg::*;
(
  input  logic                           clk,
  input  logic                           reset,
  input  logic                           run,
  input  logic                           imem_we,
  input  logic [$clog2(`IMEM_DEPTH)-1:0] imem_addr,
  input  logic [`XLEN-1:0]               imem_data,
  input  logic [`REG_ADDR_W-1:0]         dbg_reg_addr,
  output logic [`XLEN-1:0]               dbg_reg_data,
  output logic                           is_halted
);

  localparam int imem_aw = $clog2(`IMEM_DEPTH);
  localparam int dmem_aw = $clog2(`DMEM_DEPTH);

  logic [`XLEN-1:0] imem [`IMEM_DEPTH];
  logic [`XLEN-1:0] dmem [`DMEM_DEPTH];

  logic clear, stall, flush, fetch_hold, redirect, halt_set;
  logic [`XLEN-1:0] pc, fetch_instr, redirect_pc;
  fwd_sel_e fwd_a, fwd_b;

  logic             if_id_valid;
  logic [`XLEN-1:0] if_id_instr, if_id_pc;

  logic             id_valid, id_is_ecall, id_uses_rs1, id_uses_rs2;
  logic [`REG_ADDR_W-1:0] id_rs1;
  logic [`XLEN-1:0] rf_rs1_data, rf_rs2_data, d_imm;
  logic             d_reg_write, d_mem_read, d_mem_write, d_alu_src;
  logic             d_is_ecall, d_uses_rs1, d_uses_rs2;
  wb_sel_e          d_wb_sel;
  alu_op_e          d_alu_op;
  xfer_e            d_xfer;

  logic             id_ex_valid, id_ex_reg_write, id_ex_mem_read, id_ex_mem_write;
  logic             id_ex_alu_src;
  logic [`XLEN-1:0] id_ex_pc, id_ex_rs1_data, id_ex_rs2_data, id_ex_imm;
  logic [`REG_ADDR_W-1:0] id_ex_rs1, id_ex_rs2, id_ex_rd;
  wb_sel_e          id_ex_wb_sel;
  alu_op_e          id_ex_alu_op;
  branch_e          id_ex_branch_cond;
  xfer_e            id_ex_xfer, ex_xfer;
  logic             ex_reg_write, ex_mem_read;
  logic [`XLEN-1:0] exec_result, store_data;

  logic             ex_mem_valid, ex_mem_reg_write, ex_mem_mem_write, mem_reg_write, mem_we;
  logic [`XLEN-1:0] ex_mem_result, ex_mem_store_data, mem_load_data;
  logic [`REG_ADDR_W-1:0] ex_mem_rd;
  wb_sel_e          ex_mem_wb_sel;

  logic             mem_wb_valid, mem_wb_reg_write, wb_we;
  logic [`XLEN-1:0] mem_wb_result, mem_wb_load_data, wb_value;
  logic [`REG_ADDR_W-1:0] mem_wb_rd;
  wb_sel_e          mem_wb_wb_sel;

  assign clear      = reset || !run;   // run low parks the core at pc 0
  assign fetch_hold = stall || is_halted;

  always_ff @(posedge clk) begin
    if (imem_we)
      imem[imem_addr] <= imem_data;  // loader port
  end

  assign fetch_instr = imem[pc[imem_aw+1:2]];

  always_ff @(posedge clk) begin
    if (clear)
      pc <= '0;
    else if (flush)
      pc <= redirect_pc;  // taken branch or jump from execute
    else if (!fetch_hold)
      pc <= pc + `XLEN'(`PC_STEP);
  end

  always_ff @(posedge clk) begin
    if (clear || flush)
      if_id_valid <= 1'b0;
    else if (!fetch_hold)
      if_id_valid <= 1'b1;
  end

  always_ff @(posedge clk) begin
    if (!fetch_hold) begin
      if_id_instr <= fetch_instr;
      if_id_pc    <= pc;
    end
  end

  decode_unit u_decode (
    .instr(if_id_instr), .reg_write(d_reg_write), .mem_read(d_mem_read),
    .mem_write(d_mem_write), .wb_sel(d_wb_sel), .alu_src(d_alu_src), .alu_op(d_alu_op),
    .xfer(d_xfer), .is_ecall(d_is_ecall), .uses_rs1(d_uses_rs1), .uses_rs2(d_uses_rs2),
    .imm(d_imm)
  );

  assign id_valid    = if_id_valid && !is_halted;  // nothing past the ecall enters execute
  assign id_is_ecall = id_valid && d_is_ecall;
  assign id_uses_rs1 = id_valid && d_uses_rs1;
  assign id_uses_rs2 = id_valid && d_uses_rs2;
  assign id_rs1      = d_is_ecall ? `REG_ADDR_W'(`HALT_REG) : if_id_instr[19:15];

  reg_file u_reg_file (
    .clk(clk), .rs1_addr(id_rs1), .rs2_addr(if_id_instr[24:20]), .dbg_addr(dbg_reg_addr),
    .rd_addr(mem_wb_rd), .rd_data(wb_value), .rd_we(wb_we),
    .rs1_data(rf_rs1_data), .rs2_data(rf_rs2_data), .dbg_data(dbg_reg_data)
  );

  // stalled ecall sees stale x17, flushed one is on the wrong path
  assign halt_set = id_is_ecall && !stall && !flush && rf_rs1_data == `XLEN'(`HALT_CODE);

  always_ff @(posedge clk) begin
    if (clear)
      is_halted <= 1'b0;
    else if (halt_set)
      is_halted <= 1'b1;  // sticky until reset or run low
  end

  always_ff @(posedge clk) begin
    if (clear || flush || stall)
      id_ex_valid <= 1'b0;  // bubble
    else
      id_ex_valid <= id_valid;
  end

  always_ff @(posedge clk) begin
    id_ex_pc          <= if_id_pc;
    id_ex_rs1_data    <= rf_rs1_data;
    id_ex_rs2_data    <= rf_rs2_data;
    id_ex_imm         <= d_imm;
    id_ex_rs1         <= id_rs1;
    id_ex_rs2         <= if_id_instr[24:20];
    id_ex_rd          <= if_id_instr[11:7];
    id_ex_reg_write   <= d_reg_write;
    id_ex_mem_read    <= d_mem_read;
    id_ex_mem_write   <= d_mem_write;
    id_ex_wb_sel      <= d_wb_sel;
    id_ex_alu_src     <= d_alu_src;
    id_ex_alu_op      <= d_alu_op;
    id_ex_branch_cond <= branch_e'(if_id_instr[14:12]);
    id_ex_xfer        <= d_xfer;
  end

  assign ex_reg_write = id_ex_valid && id_ex_reg_write;
  assign ex_mem_read  = id_ex_valid && id_ex_mem_read;
  assign ex_xfer      = id_ex_valid ? id_ex_xfer : xfer_none;  // bubble never redirects

  execute_unit u_execute (
    .pc(id_ex_pc), .rs1_data(id_ex_rs1_data), .rs2_data(id_ex_rs2_data), .imm(id_ex_imm),
    .alu_src(id_ex_alu_src), .alu_op(id_ex_alu_op), .branch_cond(id_ex_branch_cond),
    .xfer(ex_xfer), .fwd_a(fwd_a), .fwd_b(fwd_b), .mem_value(ex_mem_result),
    .wb_value(wb_value), .exec_result(exec_result), .store_data(store_data),
    .redirect(redirect), .redirect_pc(redirect_pc)
  );

  hazard_unit u_hazard (
    .id_rs1(id_rs1), .id_rs2(if_id_instr[24:20]), .id_uses_rs1(id_uses_rs1),
    .id_uses_rs2(id_uses_rs2), .id_is_ecall(id_is_ecall), .ex_rs1(id_ex_rs1),
    .ex_rs2(id_ex_rs2), .ex_rd(id_ex_rd), .ex_mem_read(ex_mem_read),
    .ex_reg_write(ex_reg_write), .mem_rd(ex_mem_rd), .mem_reg_write(mem_reg_write),
    .wb_rd(mem_wb_rd), .wb_reg_write(wb_we), .redirect(redirect),
    .stall(stall), .flush(flush), .fwd_a(fwd_a), .fwd_b(fwd_b)
  );

  always_ff @(posedge clk) begin
    if (clear)
      ex_mem_valid <= 1'b0;
    else
      ex_mem_valid <= id_ex_valid;
  end

  always_ff @(posedge clk) begin
    ex_mem_result     <= exec_result;
    ex_mem_store_data <= store_data;
    ex_mem_rd         <= id_ex_rd;
    ex_mem_reg_write  <= id_ex_reg_write;
    ex_mem_mem_write  <= id_ex_mem_write;
    ex_mem_wb_sel     <= id_ex_wb_sel;
  end

  assign mem_reg_write = ex_mem_valid && ex_mem_reg_write;
  assign mem_we        = ex_mem_valid && ex_mem_mem_write;

  always_ff @(posedge clk) begin
    if (mem_we)
      dmem[ex_mem_result[dmem_aw+1:2]] <= ex_mem_store_data;  // word store
  end

  assign mem_load_data = dmem[ex_mem_result[dmem_aw+1:2]];  // single cycle read

  always_ff @(posedge clk) begin
    if (clear)
      mem_wb_valid <= 1'b0;
    else
      mem_wb_valid <= ex_mem_valid;
  end

  always_ff @(posedge clk) begin
    mem_wb_result    <= ex_mem_result;
    mem_wb_load_data <= mem_load_data;
    mem_wb_rd        <= ex_mem_rd;
    mem_wb_reg_write <= ex_mem_reg_write;
    mem_wb_wb_sel    <= ex_mem_wb_sel;
  end

  assign wb_we    = mem_wb_valid && mem_wb_reg_write;
  assign wb_value = (mem_wb_wb_sel == wb_mem) ? mem_wb_load_data : mem_wb_result;

endmodule

// File: tb/clock_gen.sv
module clock_gen (
  output logic clk,
  output logic reset
);

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;  // period 40
  end

  initial begin
    reset = 1'b1;
    repeat (3) @(posedge clk);
    reset <= 1'b0;  // released after three rising edges
  end

endmodule

// File: tb/cpu_tb.sv
`include "cpu_settings.svh"

module cpu_tb;

  localparam int imem_aw = $clog2(`IMEM_DEPTH);
  localparam int opc_imm = 'h13;
  localparam int opc_load = 'h03;
  localparam int opc_jalr = 'h67;

  logic                   clk;
  logic                   reset;
  logic                   run;
  logic                   imem_we;
  logic [imem_aw-1:0]     imem_addr;
  logic [`XLEN-1:0]       imem_data;
  logic [`REG_ADDR_W-1:0] dbg_reg_addr;
  logic [`XLEN-1:0]       dbg_reg_data;
  logic                   is_halted;

  logic [31:0] prog [$];  // program being assembled
  int          errors = 0;
  int          checks = 0;

  clock_gen clock_gen_i (.clk(clk), .reset(reset));

  cpu cpu_i (
    .clk(clk), .reset(reset), .run(run), .imem_we(imem_we), .imem_addr(imem_addr),
    .imem_data(imem_data), .dbg_reg_addr(dbg_reg_addr), .dbg_reg_data(dbg_reg_data),
    .is_halted(is_halted)
  );

  function automatic logic [31:0] alu_rr(int f3, int f7, int rd, int rs1, int rs2);
    return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'b0110011};
  endfunction

  function automatic logic [31:0] i_type(int opc, int f3, int rd, int rs1, int imm);
    return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], opc[6:0]};
  endfunction

  function automatic logic [31:0] addi(int rd, int rs1, int imm);
    return i_type(opc_imm, 0, rd, rs1, imm);
  endfunction

  function automatic logic [31:0] store_word(int rs2, int rs1, int imm);
    return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], 7'b0100011};
  endfunction

  function automatic logic [31:0] branch(int f3, int rs1, int rs2, int off);
    return {off[12], off[10:5], rs2[4:0], rs1[4:0], f3[2:0], off[4:1], off[11], 7'b1100011};
  endfunction

  function automatic logic [31:0] jump_link(int rd, int off);
    return {off[20], off[10:1], off[11], off[19:12], rd[4:0], 7'b1101111};
  endfunction

  function automatic void emit(logic [31:0] word);
    prog.push_back(word);
  endfunction

  // every program ends this way
  function automatic void emit_halt();
    emit(addi(`HALT_REG, 0, `HALT_CODE));
    emit(32'h0000_0073);  // ecall
  endfunction

  // wrong-path filler, counts into x20 if it ever retires
  function automatic void pad_wrong_path(int n);
    for (int k = 0; k < n; k++)
      emit(addi(20, 20, 1));
  endfunction

  task automatic check(input string name, input logic [31:0] expected,
                       input logic [31:0] actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("ERR %s expected %h actual %h", name, expected, actual);
    end
  endtask

  task automatic check_reg(input string name, input int idx, input logic [31:0] expected);
    logic [31:0] actual;
    @(posedge clk);
    dbg_reg_addr <= 5'(idx);
    @(negedge clk);
    actual = dbg_reg_data;  // combinational port, settled by now
    check($sformatf("%s x%0d", name, idx), expected, actual);
  endtask

  // park the core, load prog, release it and wait for the halt
  task automatic run_program(input string name);
    int cycles;
    @(posedge clk);
    run <= 1'b0;
    foreach (prog[i]) begin
      @(posedge clk);
      imem_we   <= 1'b1;
      imem_addr <= imem_aw'(i);
      imem_data <= prog[i];
    end
    @(posedge clk);
    imem_we <= 1'b0;
    run     <= 1'b1;
    cycles = 0;
    @(negedge clk);
    while (!is_halted && cycles < 2000) begin
      @(negedge clk);
      cycles++;
    end
    if (!is_halted) begin
      $display("%s: the cpu did not halt within 2000 cycles", name);
      errors++;
    end
    prog.delete();
  endtask

  task automatic test_alu();
    logic [31:0] expected [16] = '{100, 93, 193, 93, 65, 93, 156, 3, 1248, 78, 0, 1,
                                   -5, 12, 60, ~32'd60};
    emit(addi(1, 0, 100));
    emit(addi(2, 1, -7));           // 93, forwarded from mem
    emit(alu_rr(0, 0, 3, 1, 2));    // add, 193
    emit(alu_rr(0, 'h20, 4, 3, 1)); // sub, 93
    emit(alu_rr(7, 0, 5, 3, 2));    // and
    emit(alu_rr(6, 0, 6, 5, 4));    // or
    emit(alu_rr(4, 0, 7, 6, 3));    // xor
    emit(addi(8, 0, 3));
    emit(alu_rr(1, 0, 9, 7, 8));    // sll by 3
    emit(alu_rr(5, 0, 10, 9, 1));   // srl, only low 5 bits of 100 count
    emit(addi(13, 0, -5));
    emit(alu_rr(2, 0, 11, 4, 10));  // slt false
    emit(alu_rr(2, 0, 12, 13, 10)); // slt signed true
    emit(i_type(opc_imm, 7, 14, 7, 15));
    emit(i_type(opc_imm, 6, 15, 14, 48));
    emit(i_type(opc_imm, 4, 16, 15, -1));
    emit(addi(0, 0, 5));            // x0 must ignore this
    emit_halt();
    run_program("alu");
    check_reg("alu", 0, 32'd0);
    for (int r = 1; r <= 16; r++)
      check_reg("alu", r, expected[r-1]);
  endtask

  task automatic test_load_use();
    emit(addi(1, 0, 64));
    emit(addi(2, 0, 1234));
    emit(store_word(2, 1, 8));
    emit(i_type(opc_load, 2, 3, 1, 8));  // lw x3, 8(x1)
    emit(alu_rr(0, 0, 4, 3, 2));         // load-use bubble here
    emit(store_word(4, 1, 0));
    emit(i_type(opc_load, 2, 7, 1, 0));
    emit(alu_rr(0, 'h20, 8, 7, 3));
    emit_halt();
    run_program("load_use");
    check_reg("load_use", 3, 32'd1234);
    check_reg("load_use", 4, 32'd2468);
    check_reg("load_use", 7, 32'd2468);
    check_reg("load_use", 8, 32'd1234);
  endtask

  task automatic test_control_flow();
    emit(addi(1, 0, 5));
    emit(addi(2, 0, -3));
    emit(addi(20, 0, 0));     // wrong-path counter
    emit(addi(21, 0, 0));     // fall-through counter
    emit(branch(0, 1, 1, 12)); // beq taken
    pad_wrong_path(2);
    emit(branch(0, 1, 2, 8));  // beq not taken
    emit(addi(21, 21, 1));
    emit(branch(1, 1, 2, 12)); // bne taken
    pad_wrong_path(2);
    emit(branch(1, 1, 1, 8));
    emit(addi(21, 21, 1));
    emit(branch(4, 2, 1, 12)); // blt, -3 < 5
    pad_wrong_path(2);
    emit(branch(4, 1, 2, 8));
    emit(addi(21, 21, 1));
    emit(branch(5, 1, 2, 12)); // bge taken
    pad_wrong_path(2);
    emit(branch(5, 2, 1, 8));
    emit(addi(21, 21, 1));
    emit(jump_link(22, 12));   // at pc 96
    pad_wrong_path(2);
    emit(addi(23, 0, 125));    // odd target, bit 0 dropped
    emit(i_type(opc_jalr, 0, 24, 23, 0));  // at pc 112, lands on 124
    pad_wrong_path(2);
    emit_halt();
    run_program("control");
    check_reg("control", 20, 32'd0);
    check_reg("control", 21, 32'd4);
    check_reg("control", 22, 32'd100);
    check_reg("control", 24, 32'd116);
  endtask

  task automatic test_halt();
    emit(addi(5, 0, 1));
    emit(addi(`HALT_REG, 0, 5));
    emit(32'h0000_0073);    // ecall with 5, no halt
    emit(addi(6, 0, 7));
    emit_halt();
    emit(addi(5, 0, 99));   // behind the halting ecall
    run_program("halt");
    check_reg("halt", 5, 32'd1);
    check_reg("halt", 6, 32'd7);
    check_reg("halt", `HALT_REG, `HALT_CODE);
  endtask

  task automatic test_random_chain();
    logic [31:0] model [8];
    int kind;
    int rd;
    int rs1;
    int rs2;
    int imm;
    model[0] = '0;
    for (int r = 1; r < 8; r++) begin
      imm = int'($urandom % 4096) - 2048;
      model[r] = imm;
      emit(addi(r, 0, imm));
    end
    for (int n = 0; n < 20; n++) begin
      kind = int'($urandom % 4);
      rd   = 1 + int'($urandom % 7);
      rs1  = int'($urandom % 8);
      rs2  = int'($urandom % 8);
      imm  = int'($urandom % 4096) - 2048;
      case (kind)
        0: begin
          emit(addi(rd, rs1, imm));
          model[rd] = model[rs1] + imm;
        end
        1: begin
          emit(alu_rr(0, 0, rd, rs1, rs2));
          model[rd] = model[rs1] + model[rs2];
        end
        2: begin
          emit(alu_rr(0, 'h20, rd, rs1, rs2));
          model[rd] = model[rs1] - model[rs2];
        end
        default: begin
          emit(alu_rr(4, 0, rd, rs1, rs2));
          model[rd] = model[rs1] ^ model[rs2];
        end
      endcase
    end
    emit_halt();
    run_program("random");
    for (int r = 1; r < 8; r++)
      check_reg("random", r, model[r]);
  endtask

  initial begin
    int cycles;
    run          = 1'b0;
    imem_we      = 1'b0;
    imem_addr    = '0;
    imem_data    = '0;
    dbg_reg_addr = '0;
    void'($urandom(32'h11b8_529e));
    cycles = 0;
    while (reset !== 1'b0 && cycles < 20) begin
      @(negedge clk);
      cycles++;
    end
    if (reset !== 1'b0) begin
      $display("reset was never released");
      errors++;
    end
    test_alu();
    test_load_use();
    test_control_flow();
    test_halt();
    test_random_chain();
    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0)
      $display("TEST PASS");
    else
      $display("TEST FAIL");
    $finish;
  end

endmodule

// File: all.f
+incdir+rtl
rtl/isa_pkg.sv
rtl/pipe_pkg.sv
rtl/decode_unit.sv
rtl/reg_file.sv
rtl/execute_unit.sv
rtl/hazard_unit.sv
rtl/cpu.sv
tb/clock_gen.sv
tb/cpu_tb.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing -j 0
TOP       = cpu_tb
FILELIST  = all.f
OBJ_DIR   = obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST PASS"

clean:
	rm -rf $(OBJ_DIR)
